// ==== sim.f ====
common/crg_pkg.sv
hw/core_pll_decode.sv
hw/link_pll_decode.sv
pll_seq/pll_program_seq.sv
hw/crg_top.sv
sim/tb_crg_top.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_crg_top
FILELIST = sim.f
FLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_crg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_crg_top;

    import crg_pkg::*;

    localparam int RST_CNT_END    = 40;
    localparam int CLK_PERIOD     = 100;
    localparam int SWEEP_ROUNDS   = 16;
    localparam int RAND_ROUNDS    = 8;
    localparam int ROUNDS         = SWEEP_ROUNDS + 2 + RAND_ROUNDS;
    localparam int SEQ_MAX_CYCLES = 2 * 20 + RST_CNT_END + 10;
    localparam longint WATCHDOG_NS = longint'(ROUNDS + 2) * SEQ_MAX_CYCLES * CLK_PERIOD;

    logic        sys_clk = 1'b0;
    logic        sys_rst;
    pll_strap_t  pll_cfg;
    logic        pll_prog_req;
    pll_prog_t   pll_prog;
    logic        pll_prog_ack;
    logic        core_rst_n;
    logic        link_rst_n;

    logic [31:0] lfsr = 32'h6849_da72;
    int          value_errors = 0;
    int          protocol_errors = 0;

    // monitor state
    logic        prev_req;
    logic        prev_ack;
    logic        prev_rst;
    pll_prog_t   prev_prog;
    pll_target_e exp_target;
    pll_target_e last_target;
    int          cycle;
    int          rel_due;
    int          xfer_count;
    int          seq_xfers;
    logic        link_done;

    crg_top #(
        .RST_CNT_END (RST_CNT_END)
    ) i_crg_top (
        .sys_clk        (sys_clk),
        .sys_rst        (sys_rst),
        .pll_cfg_i      (pll_cfg),
        .pll_prog_req_o (pll_prog_req),
        .pll_prog_o     (pll_prog),
        .pll_prog_ack_i (pll_prog_ack),
        .core_rst_n_o   (core_rst_n),
        .link_rst_n_o   (link_rst_n)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic pll_setting_t core_model(input logic [3:0] code);
        pll_setting_t s;
        s.bypass   = 1'b1;
        s.refdiv   = 6'd2;
        s.fbdiv    = 12'd20;
        s.postdiv1 = 3'd1;
        s.postdiv2 = 3'd1;
        if (code >= 4'd1 && code <= 4'd8) begin
            s.bypass   = 1'b0;
            s.fbdiv    = 12'd4 * (12'(code) + 12'd4);
            s.postdiv1 = 3'd2;
        end
        return s;
    endfunction

    function automatic pll_setting_t link_model(input logic [1:0] code);
        pll_setting_t s;
        s = core_model(4'd0);
        case (code)
            2'd1: begin
                s.bypass   = 1'b0;
                s.refdiv   = 6'd4;
                s.fbdiv    = 12'd30;
                s.postdiv1 = 3'd5;
                s.postdiv2 = 3'd1;
            end
            2'd2: begin
                s.bypass   = 1'b0;
                s.refdiv   = 6'd2;
                s.fbdiv    = 12'd24;
                s.postdiv1 = 3'd3;
                s.postdiv2 = 3'd2;
            end
            default: begin
                s = core_model(4'd0);
            end
        endcase
        return s;
    endfunction

    // PLL side of the four-phase port
    initial begin : pll_responder
        logic [31:0] delay;
        pll_prog_ack <= 1'b0;
        forever begin
            @(posedge sys_clk);
            if (sys_rst && pll_prog_req && !pll_prog_ack) begin
                draw_bits(3, delay);
                repeat (delay) @(posedge sys_clk);
                pll_prog_ack <= 1'b1;
                @(posedge sys_clk);
                while (pll_prog_req) @(posedge sys_clk);
                pll_prog_ack <= 1'b0;
            end
        end
    end

    always @(posedge sys_clk) begin : monitor
        pll_prog_t exp_prog;
        if (!sys_rst) begin
            prev_req    <= 1'b0;
            prev_ack    <= 1'b0;
            prev_rst    <= 1'b0;
            exp_target  <= PLL_CORE;
            last_target <= PLL_CORE;
            cycle       <= 0;
            rel_due     <= 0;
            xfer_count  <= 0;
            seq_xfers   <= 0;
            link_done   <= 1'b0;
        end else begin
            cycle     <= cycle + 1;
            prev_req  <= pll_prog_req;
            prev_ack  <= pll_prog_ack;
            prev_rst  <= core_rst_n;
            prev_prog <= pll_prog;
            if (core_rst_n !== link_rst_n) begin
                $display("core and link resets differ at %0t", $time);
                protocol_errors++;
            end
            if (pll_prog_req && !prev_req) begin
                if (pll_prog_ack) begin
                    $display("request rose while ack was still high at %0t", $time);
                    protocol_errors++;
                end
                exp_prog.target  = exp_target;
                exp_prog.setting = (exp_target == PLL_CORE) ? core_model(pll_cfg.core)
                                                            : link_model(pll_cfg.link);
                if (pll_prog.target !== exp_prog.target) begin
                    $display("Fail: %0t pll_prog_o.target expected %0d got %0d",
                             $time, exp_prog.target, pll_prog.target);
                    value_errors++;
                end
                if (pll_prog.setting !== exp_prog.setting) begin
                    $display("Fail: %0t pll_prog_o.setting expected %h got %h",
                             $time, exp_prog.setting, pll_prog.setting);
                    value_errors++;
                end
                last_target <= exp_target;
                exp_target  <= (exp_target == PLL_CORE) ? PLL_LINK : PLL_CORE;
                xfer_count  <= xfer_count + 1;
                seq_xfers   <= seq_xfers + 1;
            end
            if (pll_prog_req && prev_req && pll_prog !== prev_prog) begin
                $display("Fail: %0t pll_prog_o expected %h got %h", $time, prev_prog, pll_prog);
                value_errors++;
            end
            if (!pll_prog_req && prev_req && !prev_ack) begin
                $display("request fell before ack rose at %0t", $time);
                protocol_errors++;
            end
            // counter starts the cycle after the link ack is seen low
            if (prev_ack && !pll_prog_ack && last_target == PLL_LINK) begin
                rel_due   <= cycle + 1 + RST_CNT_END;
                link_done <= 1'b1;
            end
            if (core_rst_n && !prev_rst) begin
                if (!link_done) begin
                    $display("resets released before the link transfer ended at %0t", $time);
                    protocol_errors++;
                end else if (cycle != rel_due) begin
                    $display("Fail: %0t core_rst_n_o rise cycle expected %0d got %0d",
                             $time, rel_due, cycle);
                    value_errors++;
                end
                if (seq_xfers != 2) begin
                    $display("sequence ended after %0d transfers instead of 2", seq_xfers);
                    protocol_errors++;
                end
                seq_xfers <= 0;
                link_done <= 1'b0;
            end
        end
    end

    task automatic wait_release();
        int n;
        n = 0;
        while (core_rst_n !== 1'b1 && n < SEQ_MAX_CYCLES) begin
            @(posedge sys_clk);
            n++;
        end
        if (core_rst_n !== 1'b1) begin
            $display("resets were not released within %0d cycles", SEQ_MAX_CYCLES);
            protocol_errors++;
        end
    endtask

    // resets must stay high and the port idle
    task automatic hold_running(input int n);
        repeat (n) begin
            @(posedge sys_clk);
            if (core_rst_n !== 1'b1 || pll_prog_req !== 1'b0) begin
                $display("resets dropped or a request appeared at %0t", $time);
                protocol_errors++;
            end
        end
    endtask

    task automatic apply_straps(input pll_strap_t new_cfg);
        logic changed;
        int   xfers_before;
        changed = (core_model(new_cfg.core) != core_model(pll_cfg.core))
               || (link_model(new_cfg.link) != link_model(pll_cfg.link));
        xfers_before = xfer_count;
        pll_cfg <= new_cfg;
        if (changed) begin
            repeat (3) @(posedge sys_clk);
            if (core_rst_n !== 1'b0) begin
                $display("Fail: %0t core_rst_n_o expected 0 got %b", $time, core_rst_n);
                value_errors++;
            end
            wait_release();
        end else begin
            hold_running(8);
            if (xfer_count != xfers_before) begin
                $display("strap write with equal settings started a transfer");
                protocol_errors++;
            end
        end
    endtask

    initial begin : stimulus
        pll_strap_t  cfg;
        logic [31:0] v;
        int          r;
        sys_rst <= 1'b0;
        // start from core bypass
        pll_cfg <= '{link: 2'd2, core: 4'd0};
        repeat (4) @(posedge sys_clk);
        sys_rst <= 1'b1;
        @(posedge sys_clk);
        if (pll_prog_req !== 1'b0 || core_rst_n !== 1'b0 || link_rst_n !== 1'b0) begin
            $display("Fail: %0t req/resets expected 000 got %b%b%b",
                     $time, pll_prog_req, core_rst_n, link_rst_n);
            value_errors++;
        end
        wait_release();

        for (r = 0; r < SWEEP_ROUNDS; r++) begin
            draw_bits(3, v);
            hold_running(int'(v));
            cfg.link = r[1:0];
            cfg.core = r[3:0];
            apply_straps(cfg);
        end

        // 9 and 12 both decode to bypass
        cfg.link = 2'd1;
        cfg.core = 4'd9;
        apply_straps(cfg);
        cfg.core = 4'd12;
        apply_straps(cfg);

        for (r = 0; r < RAND_ROUNDS; r++) begin
            draw_bits(3, v);
            hold_running(int'(v));
            draw_bits(6, v);
            apply_straps(pll_strap_t'(v[5:0]));
        end

        repeat (4) @(posedge sys_clk);
        $display("errors: %0d value, %0d protocol, %0d transfers seen",
                 value_errors, protocol_errors, xfer_count);
        if (value_errors + protocol_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/crg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module crg_top #(
    parameter int unsigned RST_CNT_END = crg_pkg::RST_CNT_END_DEFAULT
) (
    input  wire                 sys_clk,
    input  wire                 sys_rst,
    input  wire crg_pkg::pll_strap_t pll_cfg_i,
    output logic                pll_prog_req_o,
    output crg_pkg::pll_prog_t  pll_prog_o,
    input  wire                 pll_prog_ack_i,
    output logic                core_rst_n_o,
    output logic                link_rst_n_o
);

    import crg_pkg::*;

    pll_setting_t core_setting;
    pll_setting_t link_setting;

    // lower strap pins
    core_pll_decode i_core_pll_decode (
        .sys_clk        (sys_clk),
        .sys_rst        (sys_rst),
        .core_strap_i   (pll_cfg_i.core),
        .core_setting_o (core_setting)
    );

    // upper strap pins
    link_pll_decode i_link_pll_decode (
        .sys_clk        (sys_clk),
        .sys_rst        (sys_rst),
        .link_strap_i   (pll_cfg_i.link),
        .link_setting_o (link_setting)
    );

    pll_program_seq #(
        .RST_CNT_END (RST_CNT_END)
    ) i_pll_program_seq (
        .sys_clk        (sys_clk),
        .sys_rst        (sys_rst),
        .core_setting_i (core_setting),
        .link_setting_i (link_setting),
        .pll_prog_req_o (pll_prog_req_o),
        .pll_prog_o     (pll_prog_o),
        .pll_prog_ack_i (pll_prog_ack_i),
        .core_rst_n_o   (core_rst_n_o),
        .link_rst_n_o   (link_rst_n_o)
    );

endmodule

`default_nettype wire

// ==== pll_seq/pll_program_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module pll_program_seq #(
    parameter int unsigned RST_CNT_END = 131071
) (
    input  wire                   sys_clk,
    input  wire                   sys_rst,
    input  wire crg_pkg::pll_setting_t core_setting_i,
    input  wire crg_pkg::pll_setting_t link_setting_i,
    output logic                  pll_prog_req_o,
    output crg_pkg::pll_prog_t    pll_prog_o,
    input  wire                   pll_prog_ack_i,
    output logic                  core_rst_n_o,
    output logic                  link_rst_n_o
);

    import crg_pkg::*;

    localparam int CNT_W = $clog2(RST_CNT_END + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RST_CNT_END - 1);

    typedef enum logic [2:0] {
        IDLE,
        CORE_REQ,
        CORE_DONE,
        LINK_REQ,
        LINK_DONE,
        COUNT,
        RUN
    } seq_state_e;

    seq_state_e       state;
    logic [CNT_W-1:0] rst_cnt;
    pll_setting_t     core_snap;
    pll_setting_t     link_snap;
    logic             link_phase;
    logic             setting_changed;

    assign setting_changed = (core_setting_i != core_snap) || (link_setting_i != link_snap);

    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            state   <= IDLE;
            rst_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    state <= CORE_REQ;
                end
                CORE_REQ: begin
                    if (pll_prog_ack_i) begin
                        state <= CORE_DONE;
                    end
                end
                // wait for ack to drop before the next request
                CORE_DONE: begin
                    if (!pll_prog_ack_i) begin
                        state <= LINK_REQ;
                    end
                end
                LINK_REQ: begin
                    if (pll_prog_ack_i) begin
                        state <= LINK_DONE;
                    end
                end
                LINK_DONE: begin
                    if (!pll_prog_ack_i) begin
                        state   <= COUNT;
                        rst_cnt <= '0;
                    end
                end
                COUNT: begin
                    if (rst_cnt == CNT_LAST) begin
                        state <= RUN;
                    end else begin
                        rst_cnt <= rst_cnt + 1'b1;
                    end
                end
                RUN: begin
                    // strap moved, go around again
                    if (setting_changed) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // settings captured as each request goes up
    always_ff @(posedge sys_clk) begin
        if (state == IDLE) begin
            core_snap <= core_setting_i;
        end
        if (state == CORE_DONE && !pll_prog_ack_i) begin
            link_snap <= link_setting_i;
        end
    end

    assign link_phase     = (state == LINK_REQ) || (state == LINK_DONE);
    assign pll_prog_req_o = (state == CORE_REQ) || (state == LINK_REQ);

    always_comb begin
        pll_prog_o.target  = link_phase ? PLL_LINK : PLL_CORE;
        pll_prog_o.setting = link_phase ? link_snap : core_snap;
    end

    assign core_rst_n_o = (state == RUN);
    assign link_rst_n_o = (state == RUN);

    a_payload_stable: assert property (
        @(posedge sys_clk) disable iff (!sys_rst)
        (pll_prog_req_o && !pll_prog_ack_i) |=> $stable(pll_prog_o)
    );

    // four-phase, a new request only after ack is gone
    a_req_after_ack_low: assert property (
        @(posedge sys_clk) disable iff (!sys_rst)
        $rose(pll_prog_req_o) |-> !pll_prog_ack_i
    );

    a_resets_equal: assert property (
        @(posedge sys_clk)
        core_rst_n_o == link_rst_n_o
    );

endmodule

`default_nettype wire

// ==== hw/link_pll_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_pll_decode (
    input  wire                   sys_clk,
    input  wire                   sys_rst,
    input  wire [1:0]             link_strap_i,
    output crg_pkg::pll_setting_t link_setting_o
);

    import crg_pkg::*;

    link_mode_e   link_mode;
    pll_setting_t setting_d;

    assign link_mode = link_mode_e'(link_strap_i);

    always_comb begin
        setting_d = PLL_SETTING_BYPASS;
        case (link_mode)
            LINK_X1P5: begin
                setting_d.bypass   = 1'b0;
                setting_d.refdiv   = 6'd4;
                setting_d.fbdiv    = 12'd30;
                setting_d.postdiv1 = 3'd5;
                setting_d.postdiv2 = 3'd1;
            end
            LINK_X2: begin
                setting_d.bypass   = 1'b0;
                setting_d.refdiv   = 6'd2;
                setting_d.fbdiv    = 12'd24;
                setting_d.postdiv1 = 3'd3;
                setting_d.postdiv2 = 3'd2;
            end
            LINK_BYPASS,
            LINK_BYPASS_HI: begin
                setting_d = PLL_SETTING_BYPASS;
            end
            default: begin
                // only an unknown strap lands here
                setting_d = 'x;
            end
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            link_setting_o <= PLL_SETTING_BYPASS;
        end else begin
            link_setting_o <= setting_d;
        end
    end

    // floating strap pins would show up here
    a_link_setting_known: assert property (
        @(posedge sys_clk) disable iff (!sys_rst)
        !$isunknown(link_setting_o)
    );

endmodule

`default_nettype wire

// ==== hw/core_pll_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_pll_decode (
    input  wire                   sys_clk,
    input  wire                   sys_rst,
    input  wire [3:0]             core_strap_i,
    output crg_pkg::pll_setting_t core_setting_o
);

    import crg_pkg::*;

    core_mode_e   core_mode;
    pll_setting_t setting_d;

    assign core_mode = core_mode_e'(core_strap_i);

    // table lookup on the live strap
    always_comb begin
        setting_d = PLL_SETTING_BYPASS;
        case (core_mode)
            CORE_X5,
            CORE_X6,
            CORE_X7,
            CORE_X8,
            CORE_X9,
            CORE_X10,
            CORE_X11,
            CORE_X12: begin
                setting_d.bypass   = 1'b0;
                setting_d.refdiv   = 6'd2;
                // fbdiv steps by 4 from 20 at code 1
                setting_d.fbdiv    = (12'(core_mode) + 12'd4) << 2;
                setting_d.postdiv1 = 3'd2;
                setting_d.postdiv2 = 3'd1;
            end
            CORE_BYPASS: begin
                setting_d = PLL_SETTING_BYPASS;
            end
            default: begin
                // unused codes
                setting_d = PLL_SETTING_BYPASS;
            end
        endcase
    end

    // one register stage, strap change visible next cycle
    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            core_setting_o <= PLL_SETTING_BYPASS;
        end else begin
            core_setting_o <= setting_d;
        end
    end

endmodule

`default_nettype wire

// ==== common/crg_pkg.sv ====
`default_nettype none

package crg_pkg;

    // strap pins, link field on the upper two pins
    typedef struct packed {
        logic [1:0] link;
        logic [3:0] core;
    } pll_strap_t;

    // codes 9 to 15 have no entry and fall back to bypass
    typedef enum logic [3:0] {
        CORE_BYPASS = 4'd0,
        CORE_X5     = 4'd1,
        CORE_X6     = 4'd2,
        CORE_X7     = 4'd3,
        CORE_X8     = 4'd4,
        CORE_X9     = 4'd5,
        CORE_X10    = 4'd6,
        CORE_X11    = 4'd7,
        CORE_X12    = 4'd8
    } core_mode_e;

    typedef enum logic [1:0] {
        LINK_BYPASS    = 2'd0,
        LINK_X1P5      = 2'd1,
        LINK_X2        = 2'd2,
        LINK_BYPASS_HI = 2'd3
    } link_mode_e;

    // divider settings of one PLL macro
    typedef struct packed {
        logic        bypass;
        logic [5:0]  refdiv;
        logic [11:0] fbdiv;
        logic [2:0]  postdiv1;
        logic [2:0]  postdiv2;
    } pll_setting_t;

    typedef enum logic {
        PLL_CORE = 1'b0,
        PLL_LINK = 1'b1
    } pll_target_e;

    // word sent over the configuration port
    typedef struct packed {
        pll_target_e  target;
        pll_setting_t setting;
    } pll_prog_t;

    // common to both bypass entries
    localparam pll_setting_t PLL_SETTING_BYPASS = '{
        bypass:   1'b1,
        refdiv:   6'd2,
        fbdiv:    12'd20,
        postdiv1: 3'd1,
        postdiv2: 3'd1
    };

    localparam int unsigned RST_CNT_END_DEFAULT = 131071;

endpackage

`default_nettype wire
